// File: hw/pdp8_isa_pkg.sv
package pdp8_isa_pkg;

    localparam int word_bits = 12;
    localparam int addr_bits = 12;
    localparam int field_bits = 3;
    localparam int mem_words = 1 << addr_bits;

    // Instruction layout, bit 0 is the LSB
    localparam int opcode_lsb = 9;
    localparam int offset_bits = 7;  // Address within a page

    typedef enum logic [2:0]
    {
        and_op = 3'o0,
        tad_op = 3'o1,
        isz_op = 3'o2,
        dca_op = 3'o3,
        jms_op = 3'o4,
        jmp_op = 3'o5,
        iot_op = 3'o6,
        opr_op = 3'o7
    } opcode_t;

    // Memory reference bits
    localparam int indirect_bit = 8;
    localparam int page_bit = 7;  // Set for current page

    // Operate bits
    localparam int group_bit = 8;
    localparam int cla_bit = 7;
    localparam int cll_bit = 6;
    localparam int cma_bit = 5;
    localparam int cml_bit = 4;
    localparam int iac_bit = 0;
    localparam int hlt_bit = 1;  // Group 2 only

endpackage

// File: hw/panel_pkg.sv
package panel_pkg;

    // One-hot major states of the processor
    typedef enum logic [4:0]
    {
        F0 = 5'b00001,  // Fetch
        D0 = 5'b00010,  // Defer
        E0 = 5'b00100,  // Execute
        H0 = 5'b01000,  // Halted
        HW = 5'b10000   // Halted, key still down
    } major_state_t;

    // Front panel key sequencer
    typedef enum logic [2:0]
    {
        wait_st  = 3'd0,
        trig1    = 3'd1,
        trig2    = 3'd2,
        trig3    = 3'd3,
        delay_st = 3'd4,
        reenable = 3'd5
    } trig_state_t;

    // Debounce counter is one bit wider, lockout ends on its top bit
    localparam int dbnce_nu_bits = 4;

endpackage

// File: hw/panel_key_if.sv
`timescale 1ns/1ps

// Qualified panel keys, all high together for four clocks per press
interface panel_key_if;

    logic trigger;
    logic clear;
    logic extd_addr;
    logic addr_load;
    logic dep;
    logic exam;
    logic cont;

    modport source
    (
        output trigger, clear, extd_addr, addr_load, dep, exam, cont
    );

    modport sink
    (
        input trigger, clear, extd_addr, addr_load, dep, exam, cont
    );

endinterface

// File: hw/front_panel.sv
`timescale 1ns/1ps

module front_panel
(
    input  logic                    clk,
    input  logic                    reset,
    input  panel_pkg::major_state_t state,
    input  logic                    clear,
    input  logic                    extd_addr,
    input  logic                    addr_load,
    input  logic                    dep,
    input  logic                    exam,
    input  logic                    cont,
    input  logic                    sing_step,
    input  logic                    halt,
    panel_key_if.source             keys
);

    panel_pkg::trig_state_t trig_state;
    logic [6:0] key_pat;  // Trigger then the six keys
    logic [panel_pkg::dbnce_nu_bits:0] trig_cnt;

    logic any_key;
    logic halted;
    logic running;
    logic cont_c;
    logic press_ok;

    assign any_key = clear | extd_addr | addr_load | dep | exam | cont;

    assign halted = (state == panel_pkg::H0) || (state == panel_pkg::HW);
    assign running = (state == panel_pkg::F0) || (state == panel_pkg::D0) ||
                     (state == panel_pkg::E0);

    // While running only cont is taken, and only when stepping or halting
    assign cont_c = cont & (sing_step | halt);

    assign press_ok = (trig_state == panel_pkg::wait_st) &&
                      ((halted && any_key) || (running && cont_c));

    assign {keys.trigger, keys.clear, keys.extd_addr, keys.addr_load,
            keys.dep, keys.exam, keys.cont} = key_pat;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            trig_state <= panel_pkg::wait_st;
            key_pat    <= '0;
            trig_cnt   <= '0;
        end
        else
        begin
            case (trig_state)
                panel_pkg::wait_st:
                    if (press_ok)
                    begin
                        trig_state <= panel_pkg::trig1;
                        key_pat    <= {1'b1, clear, extd_addr, addr_load, dep, exam, cont};
                    end
                panel_pkg::trig1:
                    trig_state <= panel_pkg::trig2;
                panel_pkg::trig2:
                    trig_state <= panel_pkg::trig3;
                panel_pkg::trig3:
                    trig_state <= panel_pkg::delay_st;
                panel_pkg::delay_st:
                begin
                    key_pat <= '0;  // Pulse ends after first delay clock
                    if (trig_cnt[panel_pkg::dbnce_nu_bits])
                        trig_state <= panel_pkg::reenable;
                end
                panel_pkg::reenable:
                    trig_state <= panel_pkg::wait_st;
                default:
                    trig_state <= panel_pkg::wait_st;
            endcase

            // Lockout timing starts over on every accepted press
            if (trig_state == panel_pkg::trig1)
                trig_cnt <= '0;
            else
                trig_cnt <= trig_cnt + 1'b1;
        end
    end

endmodule

// File: hw/core_memory.sv
`timescale 1ns/1ps

module core_memory
(
    input  logic                                 clk,
    input  logic [pdp8_isa_pkg::addr_bits-1:0]   addr,
    input  logic [pdp8_isa_pkg::word_bits-1:0]   wdata,
    input  logic                                 we,
    output logic [pdp8_isa_pkg::word_bits-1:0]   rdata
);

    logic [pdp8_isa_pkg::word_bits-1:0] mem [pdp8_isa_pkg::mem_words];

    // One port, old contents come out on a write
    always_ff @(posedge clk)
    begin
        rdata <= mem[addr];
        if (we)
            mem[addr] <= wdata;
    end

endmodule

// File: hw/cpu_control.sv
`timescale 1ns/1ps

module cpu_control
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [pdp8_isa_pkg::word_bits-1:0]    switch_reg,
    input  logic                                  sing_step,
    input  logic                                  halt,
    panel_key_if.sink                             keys,
    input  logic [pdp8_isa_pkg::word_bits-1:0]    mem_rdata,
    output logic [pdp8_isa_pkg::addr_bits-1:0]    mem_addr,
    output logic [pdp8_isa_pkg::word_bits-1:0]    mem_wdata,
    output logic                                  mem_we,
    output panel_pkg::major_state_t               state,
    output logic [pdp8_isa_pkg::addr_bits-1:0]    pc,
    output logic [pdp8_isa_pkg::word_bits-1:0]    ac,
    output logic                                  link,
    output logic [pdp8_isa_pkg::word_bits-1:0]    mb,
    output logic [pdp8_isa_pkg::field_bits-1:0]   inst_field,
    output logic                                  run
);

    logic [pdp8_isa_pkg::addr_bits-1:0] ma;
    pdp8_isa_pkg::opcode_t ir;
    logic phase;  // Low presents the address, high uses the data
    logic op_dep;
    logic op_exam;
    logic trig_q;
    logic step_req;  // Cont pulse seen, not yet used by a major state

    pdp8_isa_pkg::opcode_t fetch_op;
    logic [pdp8_isa_pkg::addr_bits-pdp8_isa_pkg::offset_bits-1:0] page_hi;
    logic [pdp8_isa_pkg::addr_bits-1:0] eaddr;
    logic [pdp8_isa_pkg::word_bits:0] opr_lac;
    logic [pdp8_isa_pkg::word_bits:0] tad_sum;
    logic [pdp8_isa_pkg::word_bits-1:0] isz_inc;
    logic hlt_now;
    logic stop;
    logic f0_done;
    logic advance;

    assign fetch_op = pdp8_isa_pkg::opcode_t'(
        mem_rdata[pdp8_isa_pkg::word_bits-1:pdp8_isa_pkg::opcode_lsb]);

    assign page_hi = mem_rdata[pdp8_isa_pkg::page_bit] ?
                     pc[pdp8_isa_pkg::addr_bits-1:pdp8_isa_pkg::offset_bits] : '0;
    assign eaddr = {page_hi, mem_rdata[pdp8_isa_pkg::offset_bits-1:0]};

    assign tad_sum = {1'b0, ac} + {1'b0, mem_rdata};
    assign isz_inc = mem_rdata + 1'b1;

    assign hlt_now = (fetch_op == pdp8_isa_pkg::opr_op) &&
                     mem_rdata[pdp8_isa_pkg::group_bit] && mem_rdata[pdp8_isa_pkg::hlt_bit];
    assign stop = halt | ((state == panel_pkg::F0) && hlt_now);

    // Instructions that finish in the fetch cycle
    assign f0_done = (fetch_op == pdp8_isa_pkg::opr_op) ||
                     (fetch_op == pdp8_isa_pkg::iot_op) ||
                     ((fetch_op == pdp8_isa_pkg::jmp_op) &&
                      !mem_rdata[pdp8_isa_pkg::indirect_bit]);

    assign advance = ((state == panel_pkg::F0) || (state == panel_pkg::D0) ||
                      (state == panel_pkg::E0)) && !phase && (!sing_step || step_req);

    assign mem_addr = ((state == panel_pkg::F0) || (state == panel_pkg::H0)) ? pc : ma;

    // Group 1 microcode sequence
    always_comb
    begin
        opr_lac = {link, ac};
        if (mem_rdata[pdp8_isa_pkg::cla_bit])
            opr_lac[pdp8_isa_pkg::word_bits-1:0] = '0;
        if (mem_rdata[pdp8_isa_pkg::cll_bit])
            opr_lac[pdp8_isa_pkg::word_bits] = 1'b0;
        if (mem_rdata[pdp8_isa_pkg::cma_bit])
            opr_lac[pdp8_isa_pkg::word_bits-1:0] = ~opr_lac[pdp8_isa_pkg::word_bits-1:0];
        if (mem_rdata[pdp8_isa_pkg::cml_bit])
            opr_lac[pdp8_isa_pkg::word_bits] = ~opr_lac[pdp8_isa_pkg::word_bits];
        if (mem_rdata[pdp8_isa_pkg::iac_bit])
            opr_lac = opr_lac + 1'b1;  // Carry flips link
    end

    always_comb
    begin
        mem_we = 1'b0;
        mem_wdata = mb;
        if (state == panel_pkg::HW)
            mem_we = op_dep;
        else if ((state == panel_pkg::E0) && phase)
        begin
            case (ir)
                pdp8_isa_pkg::isz_op:
                begin
                    mem_we = 1'b1;
                    mem_wdata = isz_inc;
                end
                pdp8_isa_pkg::dca_op:
                begin
                    mem_we = 1'b1;
                    mem_wdata = ac;
                end
                pdp8_isa_pkg::jms_op:
                begin
                    mem_we = 1'b1;
                    mem_wdata = pc;  // Return address
                end
                default:
                    mem_we = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= panel_pkg::H0;
            phase      <= 1'b0;
            run        <= 1'b0;
            pc         <= '0;
            ac         <= '0;
            link       <= 1'b0;
            inst_field <= '0;
            op_dep     <= 1'b0;
            op_exam    <= 1'b0;
            trig_q     <= 1'b0;
            step_req   <= 1'b0;
        end
        else
        begin
            trig_q <= keys.trigger;
            // The cont that starts a stepped run also releases the first fetch
            if (keys.trigger && !trig_q && keys.cont)
                step_req <= 1'b1;
            else if (!sing_step || advance)
                step_req <= 1'b0;

            if (advance)
                phase <= 1'b1;

            case (state)
                panel_pkg::H0:
                    if (keys.trigger && !trig_q)  // New press only
                    begin
                        state <= panel_pkg::HW;
                        if (keys.clear)
                        begin
                            ac   <= '0;
                            link <= 1'b0;
                        end
                        if (keys.extd_addr)
                            inst_field <= switch_reg[pdp8_isa_pkg::field_bits-1:0];
                        if (keys.addr_load)
                            pc <= switch_reg;
                        if (keys.dep || keys.exam)
                        begin
                            ma <= pc;
                            pc <= pc + 1'b1;
                        end
                        if (keys.dep)
                            mb <= switch_reg;
                        op_dep  <= keys.dep;
                        op_exam <= keys.exam;
                        run     <= keys.cont & ~halt;
                    end
                panel_pkg::HW:
                begin
                    op_dep  <= 1'b0;
                    op_exam <= 1'b0;
                    if (op_exam)
                        mb <= mem_rdata;  // Read issued in H0
                    if (!keys.trigger)
                    begin
                        state <= run ? panel_pkg::F0 : panel_pkg::H0;
                        phase <= 1'b0;
                    end
                end
                panel_pkg::F0:
                    if (phase)
                    begin
                        phase <= 1'b0;
                        mb    <= mem_rdata;
                        ir    <= fetch_op;
                        pc    <= pc + 1'b1;
                        if ((fetch_op == pdp8_isa_pkg::opr_op) &&
                            !mem_rdata[pdp8_isa_pkg::group_bit])
                            {link, ac} <= opr_lac;
                        if (fetch_op == pdp8_isa_pkg::jmp_op)
                            pc <= eaddr;  // Indirect target replaces it in D0
                        if (f0_done)
                        begin
                            state <= stop ? panel_pkg::H0 : panel_pkg::F0;
                            run   <= ~stop;
                        end
                        else
                        begin
                            ma    <= eaddr;
                            state <= mem_rdata[pdp8_isa_pkg::indirect_bit] ?
                                     panel_pkg::D0 : panel_pkg::E0;
                        end
                    end
                panel_pkg::D0:
                    if (phase)
                    begin
                        phase <= 1'b0;
                        mb    <= mem_rdata;
                        if (ir == pdp8_isa_pkg::jmp_op)
                        begin
                            pc    <= mem_rdata;
                            state <= stop ? panel_pkg::H0 : panel_pkg::F0;
                            run   <= ~stop;
                        end
                        else
                        begin
                            ma    <= mem_rdata;
                            state <= panel_pkg::E0;
                        end
                    end
                panel_pkg::E0:
                    if (phase)
                    begin
                        phase <= 1'b0;
                        state <= stop ? panel_pkg::H0 : panel_pkg::F0;
                        run   <= ~stop;
                        mb    <= mem_rdata;
                        case (ir)
                            pdp8_isa_pkg::and_op:
                                ac <= ac & mem_rdata;
                            pdp8_isa_pkg::tad_op:
                            begin
                                ac   <= tad_sum[pdp8_isa_pkg::word_bits-1:0];
                                link <= link ^ tad_sum[pdp8_isa_pkg::word_bits];
                            end
                            pdp8_isa_pkg::isz_op:
                            begin
                                mb <= isz_inc;
                                if (isz_inc == '0)
                                    pc <= pc + 1'b1;  // Skip
                            end
                            pdp8_isa_pkg::dca_op:
                            begin
                                mb <= ac;
                                ac <= '0;
                            end
                            pdp8_isa_pkg::jms_op:
                            begin
                                mb <= pc;
                                pc <= ma + 1'b1;
                            end
                            default:
                                ac <= ac;
                        endcase
                    end
                default:
                    state <= panel_pkg::H0;
            endcase
        end
    end

endmodule

// File: hw/pdp8_panel_cpu.sv
`timescale 1ns/1ps

module pdp8_panel_cpu
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [pdp8_isa_pkg::word_bits-1:0]    switch_reg,
    input  logic                                  clear,
    input  logic                                  extd_addr,
    input  logic                                  addr_load,
    input  logic                                  dep,
    input  logic                                  exam,
    input  logic                                  cont,
    input  logic                                  sing_step,
    input  logic                                  halt,
    output logic [pdp8_isa_pkg::addr_bits-1:0]    pc,
    output logic [pdp8_isa_pkg::word_bits-1:0]    ac,
    output logic                                  link,
    output logic [pdp8_isa_pkg::word_bits-1:0]    mb,
    output logic [pdp8_isa_pkg::field_bits-1:0]   inst_field,
    output logic                                  run,
    output panel_pkg::major_state_t               major_state
);

    logic [pdp8_isa_pkg::addr_bits-1:0] mem_addr;
    logic [pdp8_isa_pkg::word_bits-1:0] mem_wdata;
    logic [pdp8_isa_pkg::word_bits-1:0] mem_rdata;
    logic mem_we;

    panel_key_if u_keys ();

    front_panel u_front_panel
    (
        .clk       (clk),
        .reset     (reset),
        .state     (major_state),
        .clear     (clear),
        .extd_addr (extd_addr),
        .addr_load (addr_load),
        .dep       (dep),
        .exam      (exam),
        .cont      (cont),
        .sing_step (sing_step),
        .halt      (halt),
        .keys      (u_keys)
    );

    cpu_control u_cpu_control
    (
        .clk        (clk),
        .reset      (reset),
        .switch_reg (switch_reg),
        .sing_step  (sing_step),
        .halt       (halt),
        .keys       (u_keys),
        .mem_rdata  (mem_rdata),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we),
        .state      (major_state),
        .pc         (pc),
        .ac         (ac),
        .link       (link),
        .mb         (mb),
        .inst_field (inst_field),
        .run        (run)
    );

    core_memory u_core_memory
    (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

endmodule

// File: verif/pdp8_panel_cpu_sva.sv
`timescale 1ns/1ps

module pdp8_panel_cpu_sva
(
    input logic                    clk,
    input logic                    reset,
    input panel_pkg::trig_state_t  trig_state,
    input logic                    trigger,
    input logic                    mem_we,
    input panel_pkg::major_state_t state
);

    // Key pattern is held for exactly four clocks
    key_pulse_len: assert property (@(posedge clk) disable iff (reset)
        $rose(trigger) |-> trigger [*4] ##1 !trigger)
        else $error("key pulse length is not four clocks");

    press_in_wait: assert property (@(posedge clk) disable iff (reset)
        $rose(trigger) |-> $past(trig_state) == panel_pkg::wait_st)
        else $error("key press accepted outside wait_st");

    we_state: assert property (@(posedge clk) disable iff (reset)
        mem_we |-> (state == panel_pkg::E0) || (state == panel_pkg::HW))
        else $error("memory write outside E0 or HW");

    reset_state: assert property (@(posedge clk)
        reset |=> state == panel_pkg::H0)
        else $error("major state is not H0 after reset");

endmodule

bind pdp8_panel_cpu pdp8_panel_cpu_sva u_sva
(
    .clk        (clk),
    .reset      (reset),
    .trig_state (u_front_panel.trig_state),
    .trigger    (u_keys.trigger),
    .mem_we     (mem_we),
    .state      (major_state)
);

// File: verif/tb_pdp8_panel_cpu.sv
`timescale 1ns/1ps

module tb_pdp8_panel_cpu;

    localparam int k_clear = 0;
    localparam int k_extd = 1;
    localparam int k_load = 2;
    localparam int k_dep = 3;
    localparam int k_exam = 4;
    localparam int k_cont = 5;
    localparam int c_ac = 0;  // Row check selectors
    localparam int c_mb = 1;
    localparam int c_field = 2;
    localparam int c_none = 3;
    localparam int n_rows = 10;

    logic clk;
    logic reset;
    logic [11:0] switch_reg;
    logic clear;
    logic extd_addr;
    logic addr_load;
    logic dep;
    logic exam;
    logic cont;
    logic sing_step;
    logic halt;
    logic [11:0] pc;
    logic [11:0] ac;
    logic link;
    logic [11:0] mb;
    logic [2:0] inst_field;
    logic run;
    panel_pkg::major_state_t major_state;

    logic [11:0] mm [0:4095];  // Reference memory
    logic [11:0] m_pc;
    logic [11:0] m_ac;
    logic m_link;
    int m_states;
    logic [11:0] w_addr [$];
    logic [11:0] w_data [$];
    int t_key [n_rows];
    logic [11:0] t_sw [n_rows];
    int t_pc [n_rows];  // -1 leaves pc unchecked
    int t_sel [n_rows];
    int t_exp [n_rows];
    logic [11:0] r1;
    logic [11:0] r2;
    logic [11:0] r3;
    logic [11:0] r4;
    int presses;

    pdp8_panel_cpu u_pdp8_panel_cpu
    (
        .clk         (clk),
        .reset       (reset),
        .switch_reg  (switch_reg),
        .clear       (clear),
        .extd_addr   (extd_addr),
        .addr_load   (addr_load),
        .dep         (dep),
        .exam        (exam),
        .cont        (cont),
        .sing_step   (sing_step),
        .halt        (halt),
        .pc          (pc),
        .ac          (ac),
        .link        (link),
        .mb          (mb),
        .inst_field  (inst_field),
        .run         (run),
        .major_state (major_state)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    task automatic stop_run(input string line);
        $display(">>> FAIL");
        $display("%s", line);
        $fatal(1);
    endtask

    task automatic check_val(input string what, input int got, input int exp);
        assert (got == exp)
        else
            stop_run($sformatf("error at %0t: %s is %o, expected %o", $time, what, got, exp));
    endtask

    task automatic wait_state(input panel_pkg::major_state_t s, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (major_state !== s)
        begin
            n++;
            if (n > limit)
                stop_run($sformatf("timed out waiting for state %s", s.name()));
            @(negedge clk);
        end
    endtask

    task automatic wait_stop(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (run !== 1'b0 || major_state !== panel_pkg::H0)
        begin
            n++;
            if (n > limit)
                stop_run("timed out waiting for the processor to halt");
            @(negedge clk);
        end
    endtask

    task automatic wait_trigger(input logic val, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (u_pdp8_panel_cpu.u_keys.trigger !== val)
        begin
            n++;
            if (n > limit)
                stop_run("timed out waiting for a panel key pulse");
            @(negedge clk);
        end
    endtask

    task automatic set_key(input int code, input logic val);
        case (code)
            k_clear: clear = val;
            k_extd: extd_addr = val;
            k_load: addr_load = val;
            k_dep: dep = val;
            k_exam: exam = val;
            default: cont = val;
        endcase
    endtask

    // Hold until the processor takes the key, release, back in H0
    task automatic press_key(input int code, input logic [11:0] sw);
        @(posedge clk);
        #1;
        switch_reg = sw;
        set_key(code, 1'b1);
        wait_state(panel_pkg::HW, 100);
        @(posedge clk);
        #1;
        set_key(code, 1'b0);
        wait_state(panel_pkg::H0, 100);
    endtask

    task automatic start_run();
        @(posedge clk);
        #1;
        cont = 1'b1;
        wait_state(panel_pkg::HW, 100);
        @(posedge clk);
        #1;
        cont = 1'b0;
    endtask

    task automatic add_word(input logic [11:0] a, input logic [11:0] d);
        w_addr.push_back(a);
        w_data.push_back(d);
    endtask

    task automatic load_words();
        while (w_addr.size() > 0)
        begin
            press_key(k_load, w_addr[0]);
            press_key(k_dep, w_data[0]);
            mm[w_addr[0]] = w_data[0];
            void'(w_addr.pop_front());
            void'(w_data.pop_front());
        end
    endtask

    task automatic model_run(input logic [11:0] start);
        logic [11:0] ins;
        logic [11:0] ea;
        logic [12:0] lac;
        logic [2:0] op;
        logic done;
        m_pc = start;
        m_states = 0;
        done = 1'b0;
        while (!done && m_states < 100000)
        begin
            ins = mm[m_pc];
            op = ins[11:9];
            ea = {ins[7] ? m_pc[11:7] : 5'd0, ins[6:0]};  // Page of the instruction
            m_pc = m_pc + 1'b1;
            m_states++;
            if (op == 3'o7)
            begin
                if (!ins[8])
                begin
                    lac = {m_link, m_ac};
                    if (ins[7])
                        lac[11:0] = '0;
                    if (ins[6])
                        lac[12] = 1'b0;
                    if (ins[5])
                        lac[11:0] = ~lac[11:0];
                    if (ins[4])
                        lac[12] = ~lac[12];
                    if (ins[0])
                        lac = lac + 1'b1;
                    {m_link, m_ac} = lac;
                end
                else if (ins[1])
                    done = 1'b1;
            end
            else if (op != 3'o6)
            begin
                if (ins[8])
                begin
                    m_states++;  // Defer
                    ea = mm[ea];
                end
                if (op == 3'o5)
                    m_pc = ea;
                else
                begin
                    m_states++;
                    case (op)
                        3'o0: m_ac = m_ac & mm[ea];
                        3'o1:
                        begin
                            lac = {1'b0, m_ac} + {1'b0, mm[ea]};
                            m_ac = lac[11:0];
                            m_link = m_link ^ lac[12];
                        end
                        3'o2:
                        begin
                            mm[ea] = mm[ea] + 1'b1;
                            if (mm[ea] == '0)
                                m_pc = m_pc + 1'b1;
                        end
                        3'o3:
                        begin
                            mm[ea] = m_ac;
                            m_ac = '0;
                        end
                        default:
                        begin
                            mm[ea] = m_pc;
                            m_pc = ea + 1'b1;
                        end
                    endcase
                end
            end
        end
    endtask

    task automatic build_run_program();
        add_word(12'o0200, 12'o7300);  // CLA CLL
        add_word(12'o0201, 12'o1250);
        add_word(12'o0202, 12'o0251);
        add_word(12'o0203, 12'o1652);  // TAD I
        add_word(12'o0204, 12'o2253);
        add_word(12'o0205, 12'o7402);
        add_word(12'o0206, 12'o7061);  // CMA CML IAC
        add_word(12'o0207, 12'o3254);
        add_word(12'o0210, 12'o4260);
        add_word(12'o0211, 12'o5264);
        add_word(12'o0212, 12'o7402);
        add_word(12'o0213, 12'o7402);
        add_word(12'o0250, r1);
        add_word(12'o0251, r2);
        add_word(12'o0252, 12'o0060);
        add_word(12'o0060, r3);
        add_word(12'o0253, 12'o7777);
        add_word(12'o0254, 12'o0000);
        add_word(12'o0255, 12'o0213);
        add_word(12'o0256, r4);
        add_word(12'o0260, 12'o0000);
        add_word(12'o0261, 12'o1256);
        add_word(12'o0262, 12'o5660);  // Return through JMS word
        add_word(12'o0264, 12'o5655);
    endtask

    initial
    begin
        reset = 1'b1;
        switch_reg = '0;
        clear = 1'b0;
        extd_addr = 1'b0;
        addr_load = 1'b0;
        dep = 1'b0;
        exam = 1'b0;
        cont = 1'b0;
        sing_step = 1'b0;
        halt = 1'b0;
        m_ac = '0;
        m_link = 1'b0;
        void'($urandom(32'h0ca6496a));
        r1 = $urandom;
        r2 = $urandom;
        r3 = $urandom;
        r4 = $urandom;
        repeat (5)
            @(posedge clk);
        #1;
        reset = 1'b0;

        // Program run to HLT
        build_run_program();
        load_words();
        press_key(k_load, 12'o0200);
        model_run(12'o0200);
        start_run();
        wait_stop(5000);
        check_val("ac after run", ac, m_ac);
        check_val("link after run", link, m_link);
        check_val("pc after run", pc, m_pc);
        press_key(k_load, 12'o0254);
        press_key(k_exam, '0);
        check_val("DCA target", mb, mm[12'o0254]);

        // Panel operations table
        t_key = '{k_clear, k_load, k_dep, k_dep, k_dep, k_load, k_exam, k_exam, k_exam, k_extd};
        t_sw = '{12'o0, 12'o0100, r1, r2, r3, 12'o0100, 12'o0, 12'o0, 12'o0, r4};
        t_pc = '{-1, 'o100, 'o101, 'o102, 'o103, 'o100, 'o101, 'o102, 'o103, -1};
        t_sel = '{c_ac, c_none, c_none, c_none, c_none, c_none, c_mb, c_mb, c_mb, c_field};
        t_exp = '{0, 0, 0, 0, 0, 0, r1, r2, r3, r4[2:0]};
        for (int i = 0; i < n_rows; i++)
        begin
            press_key(t_key[i], t_sw[i]);
            if (t_pc[i] >= 0)
                check_val($sformatf("row %0d pc", i), pc, t_pc[i]);
            case (t_sel[i])
                c_ac:
                begin
                    check_val($sformatf("row %0d ac", i), ac, t_exp[i]);
                    check_val($sformatf("row %0d link", i), link, 0);
                end
                c_mb: check_val($sformatf("row %0d mb", i), mb, t_exp[i]);
                c_field: check_val($sformatf("row %0d field", i), inst_field, t_exp[i]);
                default: check_val($sformatf("row %0d run", i), run, 0);
            endcase
        end

        // Single step, one cont per major state
        build_run_program();
        load_words();
        press_key(k_load, 12'o0200);
        model_run(12'o0200);
        @(posedge clk);
        #1;
        sing_step = 1'b1;
        presses = 0;
        do
        begin
            @(posedge clk);
            #1;
            cont = 1'b1;
            wait_trigger(1'b1, 100);
            @(posedge clk);
            #1;
            cont = 1'b0;
            presses++;
            wait_trigger(1'b0, 20);
            repeat (4)
                @(negedge clk);
        end
        while ((run || major_state != panel_pkg::H0) && presses < 200);
        @(posedge clk);
        #1;
        sing_step = 1'b0;
        check_val("cont presses", presses, m_states);
        check_val("ac after stepping", ac, m_ac);

        // Halt switch stops a counting loop
        press_key(k_clear, '0);
        m_ac = '0;
        m_link = 1'b0;
        add_word(12'o0300, 12'o1310);
        add_word(12'o0301, 12'o2311);
        add_word(12'o0302, 12'o5300);
        add_word(12'o0303, 12'o7402);
        add_word(12'o0310, 12'o0001);
        add_word(12'o0311, 12'o7740);  // 32 passes
        load_words();
        press_key(k_load, 12'o0300);
        model_run(12'o0300);
        start_run();
        repeat (40)
            @(posedge clk);
        #1;
        halt = 1'b1;
        wait_stop(200);
        assert (pc >= 12'o0300 && pc <= 12'o0303)
        else
            stop_run($sformatf("error at %0t: halted pc %o is outside the loop", $time, pc));
        @(posedge clk);
        #1;
        halt = 1'b0;
        start_run();
        wait_stop(5000);
        check_val("ac after loop", ac, m_ac);
        check_val("pc after loop", pc, m_pc);

        // Second exam during lockout waits for the delay to end
        press_key(k_load, 12'o0300);
        press_key(k_exam, '0);
        @(posedge clk);
        #1;
        exam = 1'b1;
        repeat (8)
        begin
            @(negedge clk);
            check_val("pc during lockout", pc, 'o301);
        end
        wait_state(panel_pkg::HW, 100);
        @(posedge clk);
        #1;
        exam = 1'b0;
        wait_state(panel_pkg::H0, 100);
        check_val("pc after lockout", pc, 'o302);
        check_val("mb after lockout", mb, mm[12'o0301]);

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: pdp8_panel_cpu.f
hw/pdp8_isa_pkg.sv
hw/panel_pkg.sv
hw/panel_key_if.sv
hw/front_panel.sv
hw/core_memory.sv
hw/cpu_control.sv
hw/pdp8_panel_cpu.sv
verif/pdp8_panel_cpu_sva.sv
verif/tb_pdp8_panel_cpu.sv
